//--- run.sh
#!/usr/bin/env bash
# build and run the det_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module det_tb \
    -f verilog.f --Mdir obj_dir -o det_tb_sim > "$log" 2>&1 \
    && ./obj_dir/det_tb_sim >> "$log" 2>&1 \
    || echo "Test failed" >> "$log"
if grep -q "Test failed" "$log"; then
    echo "FAIL, see $log"
    exit 1
fi
echo "PASS"
exit 0

//--- src/det_accumulator.sv
module det_accumulator (
    input  logic           clk,
    input  logic           rst,
    input  logic           clear,
    input  logic           start_determinant,
    output det_pkg::elem_t first_matrix_sum,
    output logic           finished_determinant,
    mul_if.monitor         mul
);
    import det_pkg::*;

    // running xor of whole terms, full product width
    prod_t acc;
    // a whole term is on the result side
    logic  take;
    // sum including the term arriving now
    prod_t acc_next;

    assign take     = mul.done && mul.done_tag.is_final;
    assign acc_next = acc ^ mul.product;

    // running sum
    // zeroed by clear at the start of every run
    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
        end else if (take) begin
            acc <= acc_next;
        end
    end

    // result register and finished flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            first_matrix_sum     <= '0;
            finished_determinant <= 1'b0;
        end else begin
            if (take && mul.done_tag.is_last) begin
                // last term, keep the low 51 bits
                first_matrix_sum     <= elem_t'(acc_next);
                finished_determinant <= 1'b1;
            end else if (clear || !start_determinant) begin
                // new run or start released
                finished_determinant <= 1'b0;
            end
        end
    end

endmodule

//--- src/det_macros.svh
`ifndef DET_MACROS_SVH
`define DET_MACROS_SVH

// width of one matrix element
`define DET_ELEM_W 51

// cycles from multiply request to result
// matches the vendor multiplier pipeline
`define DET_MUL_LAT 11

// rows and columns of the matrix port
// only the upper left 2x2 or 3x3 corner is used
`define DET_DIM 4

// width of the size port
`define DET_SIZE_W 5

`endif

//--- src/det_multiplier.sv
`include "det_macros.svh"

module det_multiplier (
    input  logic clk,
    input  logic rst,
    mul_if.pipe  mul
);
    import det_pkg::*;

    // number of pipeline stages
    localparam int LAT = `DET_MUL_LAT;

    // stage registers, index 0 is the first stage
    prod_t    [LAT-1:0] prod_q;
    mul_tag_t [LAT-1:0] tag_q;
    logic     [LAT-1:0] valid_q;

    // valid and tag chain
    // cleared asynchronously like the vendor aclr input
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            tag_q   <= '0;
        end else begin
            valid_q[0] <= mul.req_valid;
            tag_q[0]   <= mul.req_tag;
            for (int i = 1; i < LAT; i++) begin
                valid_q[i] <= valid_q[i-1];
                tag_q[i]   <= tag_q[i-1];
            end
        end
    end

    // product data path
    // full 102-bit product formed in the first stage
    always_ff @(posedge clk) begin
        prod_q[0] <= prod_t'(mul.req_a) * prod_t'(mul.req_b);
        for (int i = 1; i < LAT; i++) begin
            // remaining stages only carry the product along
            prod_q[i] <= prod_q[i-1];
        end
    end

    // last stage drives the result side
    // one item per stage so results leave in issue order
    assign mul.done     = valid_q[LAT-1];
    assign mul.product  = prod_q[LAT-1];
    assign mul.done_tag = tag_q[LAT-1];

endmodule

//--- src/det_pkg.sv
`include "det_macros.svh"

package det_pkg;

    // one matrix element
    typedef logic [`DET_ELEM_W-1:0] elem_t;

    // full width product of two elements
    typedef logic [2*`DET_ELEM_W-1:0] prod_t;

    // matrix port, indexed [row][col]
    typedef elem_t [`DET_DIM-1:0][`DET_DIM-1:0] matrix_t;

    // matrix size, 2 or 3 supported
    typedef logic [`DET_SIZE_W-1:0] size_t;

    // term number, 0 to 5
    typedef logic [2:0] term_idx_t;

    // tag carried through the multiplier with each product
    typedef struct packed {
        // product is a whole term, ready to accumulate
        logic      is_final;
        // last term of the run
        logic      is_last;
        // which term the product belongs to
        term_idx_t term;
    } mul_tag_t;

endpackage

//--- src/det_sequencer.sv
module det_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  det_pkg::matrix_t first_matrix,
    input  det_pkg::size_t   size,
    input  logic             start_determinant,
    output logic             clear,
    mul_if.requester         mul
);
    import det_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_t;

    state_t    state;
    // term being issued as a first factor pair
    term_idx_t cnt;
    // size 3 run, otherwise size 2
    logic      sz3;
    // highest term number of the run
    term_idx_t last_term;

    // pair request occupies the request channel this cycle
    logic      pair_issue;
    // non-final product coming back from the multiplier
    logic      chain_in;
    // third factor request goes out this cycle
    logic      chain_go;
    // partial product and tag selected for chaining
    elem_t     chain_part;
    mul_tag_t  chain_tag;

    // one-deep hold for a partial that met a pair issue
    logic      hold_valid;
    elem_t     hold_part;
    mul_tag_t  hold_tag;

    // column indices of the current pair and of the chained term
    logic [5:0] pair_cols;
    logic [5:0] chain_cols;

    // constant term table
    // packed as {col of row 0, col of row 1, col of row 2}
    function automatic logic [5:0] term_cols(input term_idx_t t, input logic three);
        logic [5:0] cols;
        if (!three) begin
            // size 2 uses m00*m11 and m01*m10
            cols = (t == 3'd0) ? 6'b00_01_00 : 6'b01_00_00;
        end else begin
            case (t)
                3'd0:    cols = 6'b00_01_10;
                3'd1:    cols = 6'b01_10_00;
                3'd2:    cols = 6'b10_00_01;
                3'd3:    cols = 6'b10_01_00;
                3'd4:    cols = 6'b01_00_10;
                3'd5:    cols = 6'b00_10_01;
                default: cols = 6'b00_01_10;
            endcase
        end
        return cols;
    endfunction

    assign sz3        = (size == size_t'(3));
    assign last_term  = sz3 ? 3'd5 : 3'd1;
    assign pair_issue = (state == S_ISSUE);
    assign chain_in   = mul.done && !mul.done_tag.is_final;

    // held partial goes first, a fresh one passes straight through
    assign chain_part = hold_valid ? hold_part : elem_t'(mul.product);
    assign chain_tag  = hold_valid ? hold_tag : mul.done_tag;
    assign chain_go   = !pair_issue && (hold_valid || chain_in);

    assign pair_cols  = term_cols(cnt, sz3);
    assign chain_cols = term_cols(chain_tag.term, 1'b1);

    // request channel mux
    always_comb begin
        // default is the pair request of term cnt
        mul.req_valid = pair_issue;
        mul.req_a     = first_matrix[0][pair_cols[5:4]];
        mul.req_b     = first_matrix[1][pair_cols[3:2]];
        // size 2 pairs are whole terms already
        mul.req_tag   = '{is_final: !sz3,
                          is_last:  !sz3 && (cnt == last_term),
                          term:     cnt};
        if (chain_go) begin
            // truncated partial times the row 2 factor
            mul.req_valid = 1'b1;
            mul.req_a     = chain_part;
            mul.req_b     = first_matrix[2][chain_cols[1:0]];
            mul.req_tag   = '{is_final: 1'b1,
                              is_last:  chain_tag.term == last_term,
                              term:     chain_tag.term};
        end
    end

    // hold flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (pair_issue && chain_in) begin
            // channel busy, park the partial
            hold_valid <= 1'b1;
        end else if (hold_valid && !pair_issue) begin
            // drained this cycle, refill if another partial arrived
            hold_valid <= chain_in;
        end
    end

    // hold payload
    always_ff @(posedge clk) begin
        if (chain_in && (pair_issue || hold_valid)) begin
            hold_part <= elem_t'(mul.product);
            hold_tag  <= mul.done_tag;
        end
    end

    // run control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
            clear <= 1'b0;
        end else begin
            clear <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_determinant) begin
                        // new run, wipe the accumulator
                        state <= S_ISSUE;
                        cnt   <= '0;
                        clear <= 1'b1;
                    end
                end
                S_ISSUE: begin
                    // one pair per cycle
                    cnt <= cnt + 3'd1;
                    if (cnt == last_term) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // chaining runs on its own, leave once start drops
                    if (!start_determinant) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- src/det_top.sv
module det_top (
    input  logic             clk,
    input  logic             rst,
    input  det_pkg::matrix_t first_matrix,
    input  det_pkg::size_t   size,
    input  logic             start_determinant,
    output det_pkg::elem_t   first_matrix_sum,
    output logic             finished_determinant
);

    // accumulator clear pulse at the start of a run
    logic clear;

    // shared request and result channel
    mul_if mul_bus ();

    // issues factor pairs and chains partial products
    det_sequencer u_sequencer (
        .clk               (clk),
        .rst               (rst),
        .first_matrix      (first_matrix),
        .size              (size),
        .start_determinant (start_determinant),
        .clear             (clear),
        .mul               (mul_bus.requester)
    );

    // fixed latency pipelined multiplier
    det_multiplier u_multiplier (
        .clk (clk),
        .rst (rst),
        .mul (mul_bus.pipe)
    );

    // xor of whole terms, result and finished flag
    det_accumulator u_accumulator (
        .clk                  (clk),
        .rst                  (rst),
        .clear                (clear),
        .start_determinant    (start_determinant),
        .first_matrix_sum     (first_matrix_sum),
        .finished_determinant (finished_determinant),
        .mul                  (mul_bus.monitor)
    );

endmodule

//--- src/mul_if.sv
interface mul_if ();
    import det_pkg::*;

    // request side, one-cycle pulse, always accepted
    logic     req_valid;
    elem_t    req_a;
    elem_t    req_b;
    mul_tag_t req_tag;

    // result side, one-cycle pulse a fixed latency later
    logic     done;
    prod_t    product;
    mul_tag_t done_tag;

    // sequencer issues requests and chains partial products
    modport requester (
        output req_valid, req_a, req_b, req_tag,
        input  done, product, done_tag
    );

    // pipelined multiplier
    modport pipe (
        input  req_valid, req_a, req_b, req_tag,
        output done, product, done_tag
    );

    // accumulator only listens to results
    modport monitor (
        input done, product, done_tag
    );

endinterface

//--- testbench/det_assert.sv
`include "det_macros.svh"

module det_assert (
    input logic               clk,
    input logic               rst,
    input logic               req_valid,
    input det_pkg::mul_tag_t  req_tag,
    input logic               done,
    input det_pkg::mul_tag_t  done_tag,
    input det_pkg::elem_t     first_matrix_sum,
    input logic               finished_determinant
);
    timeunit 1ns;
    timeprecision 1ps;
    import det_pkg::*;

    // whole-term products issued but not yet returned
    logic [3:0] final_out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            final_out <= '0;
        end else begin
            final_out <= final_out + 4'(req_valid && req_tag.is_final)
                                   - 4'(done && done_tag.is_final);
        end
    end

    // fixed multiplier latency
    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        done == $past(req_valid, `DET_MUL_LAT))
        else $error("multiplier done not %0d cycles after request", `DET_MUL_LAT);

    // finished only once every term is in
    a_finish_after_terms: assert property (@(posedge clk) disable iff (rst)
        $rose(finished_determinant) |-> (final_out == '0))
        else $error("finished rose with %0d whole-term products outstanding", final_out);

    // result held while finished is up
    a_sum_stable: assert property (@(posedge clk) disable iff (rst)
        (finished_determinant && $past(finished_determinant)) |-> $stable(first_matrix_sum))
        else $error("result changed while finished was high");

    // outputs quiet in reset
    a_reset_values: assert property (@(posedge clk)
        rst |-> (!finished_determinant && first_matrix_sum == '0 && !req_valid))
        else $error("outputs not cleared during reset");

endmodule

bind det_top det_assert u_assert (
    .clk                  (clk),
    .rst                  (rst),
    .req_valid            (mul_bus.req_valid),
    .req_tag              (mul_bus.req_tag),
    .done                 (mul_bus.done),
    .done_tag             (mul_bus.done_tag),
    .first_matrix_sum     (first_matrix_sum),
    .finished_determinant (finished_determinant)
);

//--- testbench/det_tb.sv
`include "det_macros.svh"

module det_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import det_pkg::*;

    // table size, fixed rows come first
    localparam int NROWS = 18;
    localparam int NFIXED = 11;
    // cycle budget for the whole run
    localparam int TIMEOUT = NROWS * (2 * `DET_MUL_LAT + 20) + 50;
    // extra cycles start stays high after finished
    localparam int HOLD = 3;

    // full width operands for the truncation rows
    localparam elem_t ONES = '1;
    localparam elem_t BIT50 = 51'h4_0000_0000_0000;
    localparam elem_t ONES_M2 = 51'h7_FFFF_FFFF_FFFD;

    logic    clk;
    logic    rst;
    matrix_t first_matrix;
    size_t   size;
    logic    start_determinant;
    elem_t   first_matrix_sum;
    logic    finished_determinant;

    integer  seed;
    int      errors;
    int      cycles;

    // stimulus table, one run per row
    size_t   tbl_size [NROWS];
    matrix_t tbl_mat [NROWS];
    elem_t   tbl_exp [NROWS];

    det_top uut (
        .clk                  (clk),
        .rst                  (rst),
        .first_matrix         (first_matrix),
        .size                 (size),
        .start_determinant    (start_determinant),
        .first_matrix_sum     (first_matrix_sum),
        .finished_determinant (finished_determinant)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // stop a stuck run
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles before all rows finished", cycles);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // compare one value, stop at the first mismatch
    task automatic check_value(input string name, input elem_t expected, input elem_t actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // full width random element from two 32-bit draws
    function automatic elem_t rand_elem();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[50:0];
    endfunction

    // whole matrix random, so the unused corner differs per row
    function automatic matrix_t random_matrix();
        matrix_t m;
        for (int r = 0; r < `DET_DIM; r++) begin
            for (int c = 0; c < `DET_DIM; c++) begin
                m[r][c] = rand_elem();
            end
        end
        return m;
    endfunction

    // xor of all permutation products, each taken mod 2^51
    function automatic elem_t ref_sum(input matrix_t m, input size_t n);
        int    perm [6][3];
        elem_t term;
        elem_t sum;
        perm = '{'{0, 1, 2}, '{1, 2, 0}, '{2, 0, 1}, '{2, 1, 0}, '{1, 0, 2}, '{0, 2, 1}};
        sum = '0;
        if (n == size_t'(2)) begin
            term = m[0][0] * m[1][1];
            sum  = term;
            term = m[0][1] * m[1][0];
            sum  = sum ^ term;
        end else begin
            for (int t = 0; t < 6; t++) begin
                // 51-bit target truncates each step
                term = m[0][perm[t][0]] * m[1][perm[t][1]];
                term = term * m[2][perm[t][2]];
                sum  = sum ^ term;
            end
        end
        return sum;
    endfunction

    // write the used corner of a row from a 3x3 value list
    task automatic load_small(input int idx, input int n, input int v [9], input int exp);
        tbl_size[idx] = size_t'(n);
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                tbl_mat[idx][r][c] = elem_t'(v[3*r+c]);
            end
        end
        tbl_exp[idx] = elem_t'(exp);
    endtask

    task automatic build_table();
        int v [9];
        for (int i = 0; i < NROWS; i++) begin
            tbl_mat[i] = random_matrix();
        end
        // size 2, identity and small integers
        v = '{1, 0, 0, 0, 1, 0, 0, 0, 0};
        load_small(0, 2, v, 1);
        v = '{3, 5, 0, 6, 7, 0, 0, 0, 0};
        load_small(1, 2, v, 11);
        v = '{12, 9, 0, 4, 10, 0, 0, 0, 0};
        load_small(2, 2, v, 92);
        // size 2 near 2^51, products wrap
        v = '{0, 0, 0, 0, 0, 0, 0, 0, 0};
        load_small(3, 2, v, 0);
        tbl_mat[3][0][0] = ONES;
        tbl_mat[3][0][1] = ONES;
        tbl_mat[3][1][0] = elem_t'(2);
        tbl_mat[3][1][1] = ONES;
        tbl_exp[3] = ONES;
        load_small(4, 2, v, 1);
        tbl_mat[4][0][0] = BIT50;
        tbl_mat[4][0][1] = ONES;
        tbl_mat[4][1][0] = ONES;
        tbl_mat[4][1][1] = elem_t'(2);
        // size 3, identity, a zero, small integers
        v = '{1, 0, 0, 0, 1, 0, 0, 0, 1};
        load_small(5, 3, v, 1);
        v = '{2, 3, 1, 4, 0, 5, 1, 2, 3};
        load_small(6, 3, v, 55);
        v = '{1, 2, 3, 4, 5, 6, 7, 8, 9};
        load_small(7, 3, v, 8);
        // size 3 near 2^51
        v = '{0, 0, 0, 0, 0, 0, 0, 0, 0};
        load_small(8, 3, v, 0);
        tbl_mat[8][0][0] = ONES;
        tbl_mat[8][1][1] = ONES;
        tbl_mat[8][2][2] = ONES;
        tbl_exp[8] = ONES;
        v = '{0, 1, 0, 0, 2, 1, 0, 0, 5};
        load_small(9, 3, v, 0);
        tbl_mat[9][0][0] = BIT50;
        tbl_mat[9][2][0] = ONES_M2;
        tbl_exp[9] = ONES_M2;
        // same corner as row 7, other outside values
        v = '{1, 2, 3, 4, 5, 6, 7, 8, 9};
        load_small(10, 3, v, 8);
        // random rows, sizes alternate
        for (int i = NFIXED; i < NROWS; i++) begin
            tbl_size[i] = (i % 2 == 1) ? size_t'(3) : size_t'(2);
            tbl_exp[i]  = ref_sum(tbl_mat[i], tbl_size[i]);
        end
    endtask

    // one full run with the handshake checks
    task automatic run_row(input int idx);
        @(negedge clk);
        first_matrix      = tbl_mat[idx];
        size              = tbl_size[idx];
        start_determinant = 1'b1;
        @(negedge clk);
        while (!finished_determinant) begin
            @(negedge clk);
        end
        check_value("first_matrix_sum", tbl_exp[idx], first_matrix_sum);
        // start held, result must not move
        for (int h = 0; h < HOLD; h++) begin
            @(negedge clk);
            check_value("finished_determinant", elem_t'(1), elem_t'(finished_determinant));
            check_value("first_matrix_sum", tbl_exp[idx], first_matrix_sum);
        end
        start_determinant = 1'b0;
        // finished drops on the next edge
        @(negedge clk);
        check_value("finished_determinant", elem_t'(0), elem_t'(finished_determinant));
    endtask

    initial begin
        seed              = 32'h8154bc33;
        errors            = 0;
        rst               = 1'b1;
        first_matrix      = '0;
        size              = '0;
        start_determinant = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // reset values
        check_value("finished_determinant", elem_t'(0), elem_t'(finished_determinant));
        check_value("first_matrix_sum", elem_t'(0), first_matrix_sum);
        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/det_pkg.sv
src/mul_if.sv
src/det_multiplier.sv
src/det_sequencer.sv
src/det_accumulator.sv
src/det_top.sv
testbench/det_assert.sv
testbench/det_tb.sv
